/* project.f */
verilog/periph_pkg.sv
verilog/cmd_fifo.sv
verilog/axi_lite_front.sv
verilog/apb_sequencer.sv
verilog/apb_periphs.sv
verilog/periph_top.sv
testbench/periph_top_chk.sv
testbench/tb_periph_top.sv

/* run.sh */
#!/bin/sh
# build with verilator, then pass only if the run prints the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_top \
	-f project.f -o tb_periph_top &&
./obj_dir/tb_periph_top | grep "Everything OK" ||
{ echo "simulation failed"; exit 1; }

/* testbench/tb_periph_top.sv */
`timescale 1ns/1ps

module tb_periph_top import periph_pkg::*; ();

	localparam int FIFO_DEPTH = 4;
	localparam int LED_W = 4;
	localparam int TIMEOUT_CYC = 200;
	// awready low this long means the queues are really full
	localparam int STALL_CYC = 8;

	// register addresses built from slot number and offset
	localparam logic [ADDR_W-1:0] INTC_BASE = ADDR_W'(SLOT_INTC) << SLOT_LSB;
	localparam logic [ADDR_W-1:0] LED_BASE = ADDR_W'(SLOT_LED) << SLOT_LSB;
	localparam logic [ADDR_W-1:0] PEND_ADDR = INTC_BASE | ADDR_W'(INTC_PENDING_OFS);
	localparam logic [ADDR_W-1:0] MASK_ADDR = INTC_BASE | ADDR_W'(INTC_MASK_OFS);
	localparam logic [ADDR_W-1:0] LED_ADDR = LED_BASE | ADDR_W'(LED_VALUE_OFS);
	// slot 3 has no peripheral
	localparam logic [ADDR_W-1:0] BAD_ADDR = ADDR_W'(3) << SLOT_LSB;

	logic              clk_100m;
	logic              reset;
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic              wvalid;
	logic              wready;
	logic [1:0]        bresp;
	logic              bvalid;
	logic              bready;
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [DATA_W-1:0] rdata;
	logic [1:0]        rresp;
	logic              rvalid;
	logic              rready;
	logic [N_IRQ-1:0]  irq_src;
	logic              int_o;
	logic [LED_W-1:0]  led;

	// expected register contents
	logic [DATA_W-1:0] led_model;
	logic [DATA_W-1:0] mask_model;

	periph_top #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.LED_W      (LED_W)
	) dut_i (
		.clk_100m (clk_100m),
		.reset    (reset),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.wvalid   (wvalid),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.irq_src  (irq_src),
		.int_o    (int_o),
		.led      (led)
	);

	initial begin
		clk_100m = 1'b0;
		forever #5 clk_100m = ~clk_100m;
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// address and data go out together, each valid drops after its own handshake
	task automatic write_issue(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input logic [STRB_W-1:0] strb);
		int t = 0;
		bit aw_done = 1'b0;
		bit w_done = 1'b0;
		@(negedge clk_100m);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		while (!(aw_done && w_done)) begin
			// ready comes from registered state only
			if (awvalid && awready)
				aw_done = 1'b1;
			if (wvalid && wready)
				w_done = 1'b1;
			@(negedge clk_100m);
			if (aw_done)
				awvalid = 1'b0;
			if (w_done)
				wvalid = 1'b0;
			t++;
			if (t > TIMEOUT_CYC)
				fail_run("timeout waiting for awready or wready");
		end
	endtask

	task automatic wait_bresp(output logic [1:0] resp);
		int t = 0;
		@(negedge clk_100m);
		bready = 1'b1;
		while (!bvalid) begin
			@(negedge clk_100m);
			t++;
			if (t > TIMEOUT_CYC)
				fail_run("timeout waiting for bvalid");
		end
		resp = bresp;
		// handshake lands on the rising edge in between
		@(negedge clk_100m);
		bready = 1'b0;
	endtask

	task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input logic [STRB_W-1:0] strb, output logic [1:0] resp);
		write_issue(addr, data, strb);
		wait_bresp(resp);
	endtask

	task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
			output logic [1:0] resp);
		int t = 0;
		@(negedge clk_100m);
		araddr = addr;
		arvalid = 1'b1;
		while (!arready) begin
			@(negedge clk_100m);
			t++;
			if (t > TIMEOUT_CYC)
				fail_run("timeout waiting for arready");
		end
		@(negedge clk_100m);
		arvalid = 1'b0;
		rready = 1'b1;
		t = 0;
		while (!rvalid) begin
			@(negedge clk_100m);
			t++;
			if (t > TIMEOUT_CYC)
				fail_run("timeout waiting for rvalid");
		end
		data = rdata;
		resp = rresp;
		@(negedge clk_100m);
		rready = 1'b0;
	endtask

	task automatic write_ok(input string name, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
		logic [1:0] resp;
		axi_write(addr, data, strb, resp);
		check_resp({name, " bresp"}, resp, RESP_OKAY);
	endtask

	task automatic read_expect(input string name, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		axi_read(addr, data, resp);
		check_resp({name, " rresp"}, resp, RESP_OKAY);
		check_data(name, data, exp);
	endtask

	task automatic test_after_reset();
		check_data("led", DATA_W'(led), '0);
		check_bit("int_o", int_o, 1'b0);
		read_expect("intc mask", MASK_ADDR, '0);
		read_expect("intc pending", PEND_ADDR, '0);
	endtask

	task automatic test_led_register();
		logic [DATA_W-1:0] first;
		logic [DATA_W-1:0] second;
		first = $urandom();
		write_ok("led full", LED_ADDR, first, '1);
		led_model = first;
		read_expect("led value", LED_ADDR, led_model);
		check_data("led", DATA_W'(led), DATA_W'(led_model[LED_W-1:0]));
		second = $urandom();
		write_ok("led byte0", LED_ADDR, second, STRB_W'(1));
		// upper bytes keep the first value
		led_model = {first[DATA_W-1:8], second[7:0]};
		read_expect("led value", LED_ADDR, led_model);
		check_data("led", DATA_W'(led), DATA_W'(led_model[LED_W-1:0]));
	endtask

	task automatic test_interrupts();
		logic [N_IRQ-1:0] fired;
		fired = N_IRQ'(8'h25);
		// one cycle pulse, pending must hold it
		@(negedge clk_100m);
		irq_src = fired;
		@(negedge clk_100m);
		irq_src = '0;
		read_expect("intc pending", PEND_ADDR, DATA_W'(fired));
		check_bit("int_o", int_o, 1'b0);
		// bit 1 never fired
		write_ok("intc mask", MASK_ADDR, 32'h2, '1);
		check_bit("int_o", int_o, 1'b0);
		write_ok("intc mask", MASK_ADDR, 32'h1, '1);
		mask_model = 32'h1;
		read_expect("intc mask", MASK_ADDR, mask_model);
		check_bit("int_o", int_o, 1'b1);
		// write one to clear
		write_ok("intc pending", PEND_ADDR, DATA_W'(fired), '1);
		read_expect("intc pending", PEND_ADDR, '0);
		check_bit("int_o", int_o, 1'b0);
	endtask

	task automatic test_unmapped_slot();
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		logic [N_IRQ-1:0]  left_on;
		left_on = N_IRQ'(8'hc0);
		// pending bits outside the mask, a stray clear would wipe them
		@(negedge clk_100m);
		irq_src = left_on;
		@(negedge clk_100m);
		irq_src = '0;
		axi_read(BAD_ADDR, data, resp);
		check_resp("unmapped rresp", resp, RESP_SLVERR);
		check_data("unmapped rdata", data, '0);
		// all ones hits every led bit and every pending bit if misrouted
		axi_write(BAD_ADDR, '1, '1, resp);
		check_resp("unmapped bresp", resp, RESP_SLVERR);
		// nothing else may move
		read_expect("led value", LED_ADDR, led_model);
		read_expect("intc mask", MASK_ADDR, mask_model);
		read_expect("intc pending", PEND_ADDR, DATA_W'(left_on));
		check_data("led", DATA_W'(led), DATA_W'(led_model[LED_W-1:0]));
		check_bit("int_o", int_o, 1'b0);
	endtask

	task automatic test_back_pressure();
		logic [DATA_W-1:0] sent [$];
		logic [DATA_W-1:0] value;
		logic [1:0]        resp;
		bit                stalled = 1'b0;
		int                t;
		bready = 1'b0;
		// more writes than both queues and the held pair can take
		for (int i = 0; i < 2 * FIFO_DEPTH + 4 && !stalled; i++) begin
			t = 0;
			@(negedge clk_100m);
			while (!awready && !stalled) begin
				@(negedge clk_100m);
				t++;
				if (t > STALL_CYC)
					stalled = 1'b1;
			end
			if (!stalled) begin
				value = $urandom();
				write_issue(LED_ADDR, value, '1);
				sent.push_back(value);
			end
		end
		if (!stalled)
			fail_run("awready never fell while bready was held low");
		if (sent.size() < 2 * FIFO_DEPTH)
			fail_run("awready fell before both queues were full");
		foreach (sent[i]) begin
			wait_bresp(resp);
			check_resp("queued bresp", resp, RESP_OKAY);
		end
		led_model = sent[sent.size() - 1];
		read_expect("led value", LED_ADDR, led_model);
		check_data("led", DATA_W'(led), DATA_W'(led_model[LED_W-1:0]));
	endtask

	initial begin
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		irq_src = '0;
		led_model = '0;
		mask_model = '0;
		void'($urandom(32'h48a3_bc48));
		repeat (16) @(negedge clk_100m);
		reset = 1'b0;
		test_after_reset();
		test_led_register();
		test_interrupts();
		test_unmapped_slot();
		test_back_pressure();
		$display("Everything OK");
		$finish;
	end

endmodule

/* testbench/periph_top_chk.sv */
`timescale 1ns/1ps

module periph_top_chk import periph_pkg::*; (
	input logic              clk_100m,
	input logic              reset,
	input logic              bvalid,
	input logic              bready,
	input logic [1:0]        bresp,
	input logic              rvalid,
	input logic              rready,
	input logic [DATA_W-1:0] rdata,
	input logic [1:0]        rresp,
	input logic              int_o
);

	// b response held until bready
	b_hold: assert property (@(posedge clk_100m) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("bvalid dropped or bresp changed before bready");

	// r response held until rready
	r_hold: assert property (@(posedge clk_100m) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("rvalid dropped or read payload changed before rready");

	// first cycle out of reset
	reset_idle: assert property (@(posedge clk_100m)
		$fell(reset) |-> !bvalid && !rvalid && !int_o)
		else $error("response valid or int_o high right after reset");

endmodule

bind periph_top periph_top_chk chk_i (
	.clk_100m (clk_100m),
	.reset    (reset),
	.bvalid   (bvalid),
	.bready   (bready),
	.bresp    (bresp),
	.rvalid   (rvalid),
	.rready   (rready),
	.rdata    (rdata),
	.rresp    (rresp),
	.int_o    (int_o)
);

/* verilog/periph_top.sv */
`timescale 1ns/1ps

module periph_top import periph_pkg::*; #(
	parameter int FIFO_DEPTH = 4,
	parameter int LED_W = 4
) (
	input  logic              clk_100m,
	input  logic              reset,

	input  logic [ADDR_W-1:0] awaddr,
	input  logic              awvalid,
	output logic              awready,
	input  logic [DATA_W-1:0] wdata,
	input  logic [STRB_W-1:0] wstrb,
	input  logic              wvalid,
	output logic              wready,
	output logic [1:0]        bresp,
	output logic              bvalid,
	input  logic              bready,
	input  logic [ADDR_W-1:0] araddr,
	input  logic              arvalid,
	output logic              arready,
	output logic [DATA_W-1:0] rdata,
	output logic [1:0]        rresp,
	output logic              rvalid,
	input  logic              rready,

	input  logic [N_IRQ-1:0]  irq_src,
	output logic              int_o,
	output logic [LED_W-1:0]  led
);

	// request queue
	logic              req_push;
	apb_req_t          req_in;
	logic              req_full;
	logic              req_pop;
	apb_req_t          req_head;
	logic              req_empty;

	// response queue
	logic              rsp_push;
	apb_rsp_t          rsp_in;
	logic              rsp_full;
	logic              rsp_pop;
	apb_rsp_t          rsp_head;
	logic              rsp_empty;

	// apb bus
	logic              psel_intc;
	logic              psel_led;
	logic              penable;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [DATA_W-1:0] pwdata;
	logic [STRB_W-1:0] pstrb;
	logic [DATA_W-1:0] prdata;
	logic              pready;

	axi_lite_front front_i (
		.clk_100m  (clk_100m),
		.reset     (reset),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.req_push  (req_push),
		.req_data  (req_in),
		.req_full  (req_full),
		.rsp_pop   (rsp_pop),
		.rsp_data  (rsp_head),
		.rsp_empty (rsp_empty)
	);

	cmd_fifo #(
		.payload_t  (apb_req_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) req_fifo_i (
		.clk_100m  (clk_100m),
		.reset     (reset),
		.push      (req_push),
		.push_data (req_in),
		.full      (req_full),
		.pop       (req_pop),
		.pop_data  (req_head),
		.empty     (req_empty)
	);

	cmd_fifo #(
		.payload_t  (apb_rsp_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) rsp_fifo_i (
		.clk_100m  (clk_100m),
		.reset     (reset),
		.push      (rsp_push),
		.push_data (rsp_in),
		.full      (rsp_full),
		.pop       (rsp_pop),
		.pop_data  (rsp_head),
		.empty     (rsp_empty)
	);

	apb_sequencer seq_i (
		.clk_100m  (clk_100m),
		.reset     (reset),
		.req_pop   (req_pop),
		.req_data  (req_head),
		.req_empty (req_empty),
		.rsp_push  (rsp_push),
		.rsp_data  (rsp_in),
		.rsp_full  (rsp_full),
		.psel_intc (psel_intc),
		.psel_led  (psel_led),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.pstrb     (pstrb),
		.prdata    (prdata),
		.pready    (pready)
	);

	apb_periphs #(
		.LED_W (LED_W)
	) periphs_i (
		.clk_100m  (clk_100m),
		.reset     (reset),
		.psel_intc (psel_intc),
		.psel_led  (psel_led),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.pstrb     (pstrb),
		.prdata    (prdata),
		.pready    (pready),
		.irq_src   (irq_src),
		.int_o     (int_o),
		.led       (led)
	);

endmodule

/* verilog/apb_periphs.sv */
`timescale 1ns/1ps

module apb_periphs import periph_pkg::*; #(
	parameter int LED_W = 4
) (
	input  logic              clk_100m,
	input  logic              reset,
	input  logic              psel_intc,
	input  logic              psel_led,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [ADDR_W-1:0] paddr,
	input  logic [DATA_W-1:0] pwdata,
	input  logic [STRB_W-1:0] pstrb,
	output logic [DATA_W-1:0] prdata,
	output logic              pready,
	input  logic [N_IRQ-1:0]  irq_src,
	output logic              int_o,
	output logic [LED_W-1:0]  led
);

	logic [SLOT_LSB-1:0] ofs;
	logic [DATA_W-1:0]   bmask;
	logic                intc_wr;
	logic                led_wr;
	logic [N_IRQ-1:0]    pending;
	logic [N_IRQ-1:0]    irq_mask;
	logic [DATA_W-1:0]   led_val;

	assign ofs = paddr[SLOT_LSB-1:0];

	// zero wait states
	assign pready = penable & (psel_intc | psel_led);
	assign intc_wr = psel_intc & penable & pwrite;
	assign led_wr = psel_led & penable & pwrite;

	// byte strobes widened to bit enables
	always_comb begin
		for (int i = 0; i < STRB_W; i++)
			bmask[i*8 +: 8] = {8{pstrb[i]}};
	end

	// interrupt controller
	always_ff @(posedge clk_100m) begin
		if (reset) begin
			pending <= '0;
			irq_mask <= '0;
		end else begin
			// write 1 clears, a source still high sets it again
			if (intc_wr && ofs == INTC_PENDING_OFS)
				pending <= (pending & ~(pwdata[N_IRQ-1:0] & bmask[N_IRQ-1:0])) | irq_src;
			else
				pending <= pending | irq_src;
			if (intc_wr && ofs == INTC_MASK_OFS)
				irq_mask <= (irq_mask & ~bmask[N_IRQ-1:0])
					| (pwdata[N_IRQ-1:0] & bmask[N_IRQ-1:0]);
		end
	end

	assign int_o = |(pending & irq_mask);

	// led driver, full word kept for readback
	always_ff @(posedge clk_100m) begin
		if (reset)
			led_val <= '0;
		else if (led_wr && ofs == LED_VALUE_OFS)
			led_val <= (led_val & ~bmask) | (pwdata & bmask);
	end

	assign led = led_val[LED_W-1:0];

	// read mux, unknown offsets read as zero
	always_comb begin
		prdata = '0;
		if (psel_intc) begin
			if (ofs == INTC_PENDING_OFS)
				prdata[N_IRQ-1:0] = pending;
			else if (ofs == INTC_MASK_OFS)
				prdata[N_IRQ-1:0] = irq_mask;
		end else if (psel_led) begin
			if (ofs == LED_VALUE_OFS)
				prdata = led_val;
		end
	end

endmodule

/* verilog/apb_sequencer.sv */
`timescale 1ns/1ps

module apb_sequencer import periph_pkg::*; (
	input  logic              clk_100m,
	input  logic              reset,

	output logic              req_pop,
	input  apb_req_t          req_data,
	input  logic              req_empty,
	output logic              rsp_push,
	output apb_rsp_t          rsp_data,
	input  logic              rsp_full,

	output logic              psel_intc,
	output logic              psel_led,
	output logic              penable,
	output logic              pwrite,
	output logic [ADDR_W-1:0] paddr,
	output logic [DATA_W-1:0] pwdata,
	output logic [STRB_W-1:0] pstrb,
	input  logic [DATA_W-1:0] prdata,
	input  logic              pready
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_SETUP,
		S_ACCESS
	} state_t;

	state_t            state;
	apb_req_t          cur;
	logic [SLOT_W-1:0] slot;
	logic              hit_intc;
	logic              hit_led;
	logic              mapped;
	logic              busy;
	logic              done;

	// slot decode from the captured address
	assign slot = cur.addr[SLOT_MSB:SLOT_LSB];
	assign hit_intc = (slot == SLOT_INTC);
	assign hit_led = (slot == SLOT_LED);
	assign mapped = hit_intc | hit_led;
	assign busy = (state != S_IDLE);

	// one transfer in flight, so a free entry now is still free at push time
	assign req_pop = (state == S_IDLE) & ~req_empty & ~rsp_full & ~rsp_push;

	assign psel_intc = busy & hit_intc;
	assign psel_led = busy & hit_led;
	// unmapped slots never see an access phase on the bus
	assign penable = (state == S_ACCESS) & mapped;
	assign pwrite = cur.write;
	assign paddr = cur.addr;
	assign pwdata = cur.wdata;
	assign pstrb = cur.strb;

	// unmapped slot finishes in its first access cycle
	assign done = (state == S_ACCESS) & (pready | ~mapped);

	always_ff @(posedge clk_100m) begin
		if (reset) begin
			state <= S_IDLE;
			rsp_push <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (req_pop)
						state <= S_SETUP;
				end
				S_SETUP: state <= S_ACCESS;
				S_ACCESS: begin
					if (done)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
			// completion cycle pushes the response
			rsp_push <= done;
		end
	end

	always_ff @(posedge clk_100m) begin
		if (req_pop)
			cur <= req_data;
		if (done) begin
			// zero data for writes and for error replies
			rsp_data.rdata <= (mapped & ~cur.write) ? prdata : '0;
			rsp_data.err <= ~mapped;
			rsp_data.write <= cur.write;
		end
	end

endmodule

/* verilog/axi_lite_front.sv */
`timescale 1ns/1ps

module axi_lite_front import periph_pkg::*; (
	input  logic              clk_100m,
	input  logic              reset,

	input  logic [ADDR_W-1:0] awaddr,
	input  logic              awvalid,
	output logic              awready,
	input  logic [DATA_W-1:0] wdata,
	input  logic [STRB_W-1:0] wstrb,
	input  logic              wvalid,
	output logic              wready,
	output logic [1:0]        bresp,
	output logic              bvalid,
	input  logic              bready,
	input  logic [ADDR_W-1:0] araddr,
	input  logic              arvalid,
	output logic              arready,
	output logic [DATA_W-1:0] rdata,
	output logic [1:0]        rresp,
	output logic              rvalid,
	input  logic              rready,

	output logic              req_push,
	output apb_req_t          req_data,
	input  logic              req_full,
	output logic              rsp_pop,
	input  apb_rsp_t          rsp_data,
	input  logic              rsp_empty
);

	// one latched item per write channel
	logic              aw_held;
	logic [ADDR_W-1:0] aw_addr;
	logic              w_held;
	logic [DATA_W-1:0] w_data;
	logic [STRB_W-1:0] w_strb;
	logic              wr_push;
	logic              rd_push;
	logic [1:0]        resp_code;

	// no new item while a slot is taken or the queue is full
	assign awready = ~aw_held & ~req_full;
	assign wready = ~w_held & ~req_full;
	// read loses to a complete write pair
	assign arready = ~(aw_held & w_held) & ~req_full;

	assign wr_push = aw_held & w_held & ~req_full;
	assign rd_push = arvalid & arready;
	assign req_push = wr_push | rd_push;

	// request mux, write side first
	always_comb begin
		if (wr_push) begin
			req_data.addr = aw_addr;
			req_data.wdata = w_data;
			req_data.strb = w_strb;
			req_data.write = 1'b1;
		end else begin
			req_data.addr = araddr;
			req_data.wdata = '0;
			req_data.strb = '0;
			req_data.write = 1'b0;
		end
	end

	always_ff @(posedge clk_100m) begin
		if (reset) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
		end else begin
			// set on handshake, drop once the pair is queued
			if (awvalid & awready)
				aw_held <= 1'b1;
			else if (wr_push)
				aw_held <= 1'b0;
			if (wvalid & wready)
				w_held <= 1'b1;
			else if (wr_push)
				w_held <= 1'b0;
		end
	end

	always_ff @(posedge clk_100m) begin
		if (awvalid & awready)
			aw_addr <= awaddr;
		if (wvalid & wready) begin
			w_data <= wdata;
			w_strb <= wstrb;
		end
	end

	// head of the response queue picks b or r by its write flag
	assign resp_code = rsp_data.err ? RESP_SLVERR : RESP_OKAY;
	assign bvalid = ~rsp_empty & rsp_data.write;
	assign rvalid = ~rsp_empty & ~rsp_data.write;
	assign bresp = resp_code;
	assign rresp = resp_code;
	assign rdata = rsp_data.rdata;
	assign rsp_pop = (bvalid & bready) | (rvalid & rready);

endmodule

/* verilog/cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo import periph_pkg::*; #(
	parameter type payload_t = apb_req_t,
	parameter int  FIFO_DEPTH = 4
) (
	input  logic     clk_100m,
	input  logic     reset,
	input  logic     push,
	input  payload_t push_data,
	output logic     full,
	input  logic     pop,
	output payload_t pop_data,
	output logic     empty
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	payload_t         mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] cnt_next;
	logic             do_push;
	logic             do_pop;

	// wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	// requests against full or empty are dropped here
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;
	assign pop_data = mem[rd_ptr];

	always_comb begin
		case ({do_push, do_pop})
			2'b10: cnt_next = count + 1'b1;
			2'b01: cnt_next = count - 1'b1;
			default: cnt_next = count;
		endcase
	end

	always_ff @(posedge clk_100m) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk_100m) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= cnt_next;
			// flags follow the next count
			full <= (cnt_next == CNT_W'(FIFO_DEPTH));
			empty <= (cnt_next == '0);
		end
	end

endmodule

/* verilog/periph_pkg.sv */
package periph_pkg;

	// axi4-lite and apb bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// slot number lives in addr[11:8]
	localparam int SLOT_LSB = 8;
	localparam int SLOT_MSB = 11;
	localparam int SLOT_W = SLOT_MSB - SLOT_LSB + 1;

	// populated apb slots
	localparam logic [SLOT_W-1:0] SLOT_INTC = 'd0;
	localparam logic [SLOT_W-1:0] SLOT_LED = 'd8;

	// register offsets inside a slot
	localparam logic [SLOT_LSB-1:0] INTC_PENDING_OFS = 'h00;
	localparam logic [SLOT_LSB-1:0] INTC_MASK_OFS = 'h04;
	localparam logic [SLOT_LSB-1:0] LED_VALUE_OFS = 'h00;

	// axi response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// interrupt sources into the controller
	localparam int N_IRQ = 8;

	// queued transfer, 69 bits
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] strb;
		logic              write;
	} apb_req_t;

	// finished transfer, 34 bits
	// err set only for unmapped slots
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic              err;
		logic              write;
	} apb_rsp_t;

endpackage
